// ==== verilog/periph_pkg.sv ====
// Peripheral interconnect definitions
// Address map, slot numbers and GPIO register offsets
// Core size codes and slot request/response structs

package periph_pkg;

    // Core window and data widths
    localparam int ADDR_W       = 11;
    localparam int DATA_W       = 32;
    localparam int USER_OFS_W   = 6;
    localparam int SIMPLE_OFS_W = 4;
    localparam int NUM_SLOTS    = 16;
    localparam int SLOT_W       = $clog2(NUM_SLOTS);
    localparam int NUM_PINS     = 8;

    // Fixed slot assignments
    localparam int SLOT_GPIO      = 1;
    localparam int SLOT_UART      = 2;
    localparam int FIRST_EXT_USER = 4;
    localparam int NUM_EXT_USER   = 3;
    localparam int NUM_EXT_SIMPLE = 4;

    // GPIO register offsets inside its user slot
    localparam logic [USER_OFS_W-1:0] GPIO_OUT_OFS  = 6'h00;
    localparam logic [USER_OFS_W-1:0] GPIO_IN_OFS   = 6'h04;
    localparam logic [USER_OFS_W-1:0] FUNC_SEL_BASE = 6'h20;

    // Active-low access size codes
    localparam logic [1:0] SIZE_NONE = 2'b11;
    localparam logic [1:0] SIZE_BYTE = 2'b00;
    localparam logic [1:0] SIZE_HALF = 2'b01;
    localparam logic [1:0] SIZE_WORD = 2'b10;

    // Pin function select, simple picks the simple slot bank
    typedef struct packed {
        logic              simple;
        logic [SLOT_W-1:0] slot;
    } func_sel_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [1:0]        write_n;
        logic [1:0]        read_n;
    } core_req_t;

    typedef struct packed {
        logic [USER_OFS_W-1:0] offset;
        logic [DATA_W-1:0]     wdata;
        logic [1:0]            write_n;
        logic [1:0]            read_n;
    } user_req_t;

    typedef struct packed {
        logic [DATA_W-1:0]   rdata;
        logic                ready;
        logic [NUM_PINS-1:0] uo;
    } user_resp_t;

    typedef struct packed {
        logic [SIMPLE_OFS_W-1:0] offset;
        logic [7:0]              wdata;
        logic                    write;
    } simple_req_t;

    typedef struct packed {
        logic [7:0]          rdata;
        logic [NUM_PINS-1:0] uo;
    } simple_resp_t;

endpackage

// ==== verilog/periph_decode.sv ====
// Address decode for user and simple slots
// Strobe gating per slot and read data / ready mux

module periph_decode
    import periph_pkg::*;
(
    input  core_req_t          i_core_req,
    input  logic               i_hold_pending,
    input  logic [DATA_W-1:0]  i_gpio_rdata,
    input  user_resp_t         i_user_resp   [NUM_EXT_USER],
    input  simple_resp_t       i_simple_resp [NUM_EXT_SIMPLE],
    output user_req_t          o_user_req    [NUM_EXT_USER],
    output simple_req_t        o_simple_req  [NUM_EXT_SIMPLE],
    output logic               o_gpio_sel,
    output logic [DATA_W-1:0]  o_slot_rdata,
    output logic               o_slot_ready
);

    logic              sel_simple;
    logic [SLOT_W-1:0] user_idx;
    logic [SLOT_W-1:0] simple_idx;
    logic              write_req;
    logic [1:0]        read_n_masked;

    // Bit 10 splits the window into the user and simple halves
    assign sel_simple = i_core_req.addr[10];
    assign user_idx   = i_core_req.addr[9:6];
    assign simple_idx = i_core_req.addr[7:4];
    assign write_req  = i_core_req.write_n != SIZE_NONE;

    // No new read reaches a slot while the previous result is still held
    assign read_n_masked = i_hold_pending ? SIZE_NONE : i_core_req.read_n;

    assign o_gpio_sel = !sel_simple && (user_idx == SLOT_W'(SLOT_GPIO));

    // User slot requests
    always_comb begin
        for (int j = 0; j < NUM_EXT_USER; j++) begin
            o_user_req[j].offset  = i_core_req.addr[USER_OFS_W-1:0];
            o_user_req[j].wdata   = i_core_req.wdata;
            o_user_req[j].write_n = SIZE_NONE;
            o_user_req[j].read_n  = SIZE_NONE;
            if (!sel_simple && (user_idx == SLOT_W'(FIRST_EXT_USER + j))) begin
                o_user_req[j].write_n = i_core_req.write_n;
                o_user_req[j].read_n  = read_n_masked;
            end
        end
    end

    // Simple slot requests, byte wide
    always_comb begin
        for (int k = 0; k < NUM_EXT_SIMPLE; k++) begin
            o_simple_req[k].offset = i_core_req.addr[SIMPLE_OFS_W-1:0];
            o_simple_req[k].wdata  = i_core_req.wdata[7:0];
            o_simple_req[k].write  = sel_simple && write_req &&
                                     (simple_idx == SLOT_W'(k));
        end
    end

    // Read mux, open slots return zero and never stall
    always_comb begin
        o_slot_rdata = '0;
        o_slot_ready = 1'b1;
        if (sel_simple) begin
            for (int k = 0; k < NUM_EXT_SIMPLE; k++) begin
                if (simple_idx == SLOT_W'(k)) begin
                    o_slot_rdata = {{(DATA_W-8){1'b0}}, i_simple_resp[k].rdata};
                end
            end
        end else if (user_idx == SLOT_W'(SLOT_GPIO)) begin
            o_slot_rdata = i_gpio_rdata;
        end else begin
            for (int j = 0; j < NUM_EXT_USER; j++) begin
                if (user_idx == SLOT_W'(FIRST_EXT_USER + j)) begin
                    o_slot_rdata = i_user_resp[j].rdata;
                    o_slot_ready = i_user_resp[j].ready;
                end
            end
        end
    end

endmodule

// ==== verilog/periph_read_capture.sv ====
// Read result register with hold until read complete
// Data ready generation for the core

module periph_read_capture
    import periph_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [1:0]        i_read_n,
    input  logic [1:0]        i_write_n,
    input  logic [DATA_W-1:0] i_slot_rdata,
    input  logic              i_slot_ready,
    input  logic              i_read_complete,
    output logic              o_hold_pending,
    output logic [DATA_W-1:0] o_data_out,
    output logic              o_data_ready
);

    logic              read_req;
    logic              capture;
    logic              hold;
    logic              ready_r;
    logic [DATA_W-1:0] data_r;

    assign read_req = i_read_n != SIZE_NONE;
    assign capture  = read_req && i_slot_ready && !hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold <= 1'b0;
            end
            // A fresh capture takes priority over the complete pulse
            if (capture) begin
                hold <= 1'b1;
            end
            ready_r <= read_req && i_slot_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_r <= i_slot_rdata;
        end
    end

    assign o_hold_pending = hold;
    assign o_data_out     = data_r;

    // Writes finish in the cycle they are presented
    assign o_data_ready = ready_r || (i_write_n != SIZE_NONE);

endmodule

// ==== verilog/gpio_regs.sv ====
// GPIO output register and input pin read-back
// Eight per-pin function select registers

module gpio_regs
    import periph_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_sel,
    input  logic [USER_OFS_W-1:0] i_offset,
    input  logic [DATA_W-1:0]     i_wdata,
    input  logic [1:0]            i_write_n,
    input  logic [NUM_PINS-1:0]   i_ui_in,
    output logic [DATA_W-1:0]     o_rdata,
    output logic [NUM_PINS-1:0]   o_gpio_out,
    output func_sel_t             o_func_sel [NUM_PINS]
);

    logic                  wr_en;
    logic [USER_OFS_W-1:0] fsel_ofs;
    logic                  fsel_hit;
    logic [2:0]            fsel_idx;
    logic [NUM_PINS-1:0]   gpio_out;
    func_sel_t             func_sel [NUM_PINS];

    assign wr_en = i_sel && (i_write_n != SIZE_NONE);

    // Selects sit on word boundaries from FUNC_SEL_BASE to the end of the slot
    assign fsel_ofs = i_offset - FUNC_SEL_BASE;
    assign fsel_hit = (i_offset >= FUNC_SEL_BASE) && (fsel_ofs[1:0] == 2'b00);
    assign fsel_idx = fsel_ofs[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (wr_en && (i_offset == GPIO_OUT_OFS)) begin
            gpio_out <= i_wdata[NUM_PINS-1:0];
        end
    end

    // Pins 0 and 1 default to the UART, the rest to plain GPIO
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < NUM_PINS; p++) begin
                func_sel[p].simple <= 1'b0;
                func_sel[p].slot   <= (p < 2) ? SLOT_W'(SLOT_UART) : SLOT_W'(SLOT_GPIO);
            end
        end else if (wr_en && fsel_hit) begin
            func_sel[fsel_idx] <= func_sel_t'(i_wdata[SLOT_W:0]);
        end
    end

    always_comb begin
        o_rdata = '0;
        if (i_offset == GPIO_OUT_OFS) begin
            o_rdata[NUM_PINS-1:0] = gpio_out;
        end else if (i_offset == GPIO_IN_OFS) begin
            o_rdata[NUM_PINS-1:0] = i_ui_in;
        end else if (fsel_hit) begin
            o_rdata[SLOT_W:0] = func_sel[fsel_idx];
        end
    end

    assign o_gpio_out = gpio_out;
    assign o_func_sel = func_sel;

endmodule

// ==== verilog/pin_func_mux.sv ====
// Output pin mux driven by the per-pin function selects

module pin_func_mux
    import periph_pkg::*;
(
    input  func_sel_t           i_func_sel    [NUM_PINS],
    input  logic [NUM_PINS-1:0] i_gpio_out,
    input  user_resp_t          i_user_resp   [NUM_EXT_USER],
    input  simple_resp_t        i_simple_resp [NUM_EXT_SIMPLE],
    output logic [NUM_PINS-1:0] o_uo_out
);

    // Pin p always takes bit p of whichever slot it names
    always_comb begin
        for (int p = 0; p < NUM_PINS; p++) begin
            o_uo_out[p] = 1'b0;
            if (i_func_sel[p].simple) begin
                for (int k = 0; k < NUM_EXT_SIMPLE; k++) begin
                    if (i_func_sel[p].slot == SLOT_W'(k)) begin
                        o_uo_out[p] = i_simple_resp[k].uo[p];
                    end
                end
            end else if (i_func_sel[p].slot == SLOT_W'(SLOT_GPIO)) begin
                o_uo_out[p] = i_gpio_out[p];
            end else begin
                // UART and unused user slots fall through as zero
                for (int j = 0; j < NUM_EXT_USER; j++) begin
                    if (i_func_sel[p].slot == SLOT_W'(FIRST_EXT_USER + j)) begin
                        o_uo_out[p] = i_user_resp[j].uo[p];
                    end
                end
            end
        end
    end

endmodule

// ==== verilog/periph_top.sv ====
// Peripheral interconnect top level
// Decode, read capture, GPIO, pin mux and external slot ports

module periph_top
    import periph_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [NUM_PINS-1:0] i_ui_in,
    input  core_req_t           i_core_req,
    input  logic                i_read_complete,
    input  user_resp_t          i_user_resp   [NUM_EXT_USER],
    input  simple_resp_t        i_simple_resp [NUM_EXT_SIMPLE],
    output logic [NUM_PINS-1:0] o_uo_out,
    output logic [DATA_W-1:0]   o_data_out,
    output logic                o_data_ready,
    output user_req_t           o_user_req    [NUM_EXT_USER],
    output simple_req_t         o_simple_req  [NUM_EXT_SIMPLE]
);

    logic                hold_pending;
    logic                gpio_sel;
    logic [DATA_W-1:0]   gpio_rdata;
    logic [DATA_W-1:0]   slot_rdata;
    logic                slot_ready;
    logic [NUM_PINS-1:0] gpio_out;
    func_sel_t           func_sel [NUM_PINS];

    periph_decode u_decode (
        .i_core_req     (i_core_req),
        .i_hold_pending (hold_pending),
        .i_gpio_rdata   (gpio_rdata),
        .i_user_resp    (i_user_resp),
        .i_simple_resp  (i_simple_resp),
        .o_user_req     (o_user_req),
        .o_simple_req   (o_simple_req),
        .o_gpio_sel     (gpio_sel),
        .o_slot_rdata   (slot_rdata),
        .o_slot_ready   (slot_ready)
    );

    // Read data is registered here so slots never have to hold it
    periph_read_capture u_capture (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_n        (i_core_req.read_n),
        .i_write_n       (i_core_req.write_n),
        .i_slot_rdata    (slot_rdata),
        .i_slot_ready    (slot_ready),
        .i_read_complete (i_read_complete),
        .o_hold_pending  (hold_pending),
        .o_data_out      (o_data_out),
        .o_data_ready    (o_data_ready)
    );

    gpio_regs u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_sel      (gpio_sel),
        .i_offset   (i_core_req.addr[USER_OFS_W-1:0]),
        .i_wdata    (i_core_req.wdata),
        .i_write_n  (i_core_req.write_n),
        .i_ui_in    (i_ui_in),
        .o_rdata    (gpio_rdata),
        .o_gpio_out (gpio_out),
        .o_func_sel (func_sel)
    );

    pin_func_mux u_pin_mux (
        .i_func_sel    (func_sel),
        .i_gpio_out    (gpio_out),
        .i_user_resp   (i_user_resp),
        .i_simple_resp (i_simple_resp),
        .o_uo_out      (o_uo_out)
    );

endmodule

// ==== testbench/periph_assertions.sv ====
// Concurrent checks for periph_top
// Shadow GPIO registers, pending read model, expected pins and slot requests

module periph_assertions
    import periph_pkg::*;
(
    input logic                clk,
    input logic                rst_n,
    input logic [NUM_PINS-1:0] i_ui_in,
    input core_req_t           i_core_req,
    input logic                i_read_complete,
    input user_resp_t          i_user_resp   [NUM_EXT_USER],
    input simple_resp_t        i_simple_resp [NUM_EXT_SIMPLE],
    input logic [NUM_PINS-1:0] o_uo_out,
    input logic [DATA_W-1:0]   o_data_out,
    input logic                o_data_ready,
    input user_req_t           o_user_req    [NUM_EXT_USER],
    input simple_req_t         o_simple_req  [NUM_EXT_SIMPLE]
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned           fail_count = 0;
    logic                  is_write;
    logic                  is_read;
    logic                  hit_simple;
    logic [SLOT_W-1:0]     user_idx;
    logic [SLOT_W-1:0]     simple_idx;
    logic [USER_OFS_W-1:0] ofs;
    logic                  fsel_hit;
    logic [2:0]            fsel_idx;
    logic [NUM_PINS-1:0]   sh_out;
    logic [4:0]            sh_sel [NUM_PINS];
    logic                  pend;
    logic                  rd_ready_q;
    logic [DATA_W-1:0]     exp_rdata;
    logic [DATA_W-1:0]     held_rdata;
    logic                  exp_ready;
    logic [NUM_PINS-1:0]   exp_uo;
    logic                  req_ok;

    assign is_write   = i_core_req.write_n != SIZE_NONE;
    assign is_read    = i_core_req.read_n != SIZE_NONE;
    assign hit_simple = i_core_req.addr[10];
    assign user_idx   = i_core_req.addr[9:6];
    assign simple_idx = i_core_req.addr[7:4];
    assign ofs        = i_core_req.addr[USER_OFS_W-1:0];
    // Selects fill 0x20 to 0x3c, one per word
    assign fsel_hit   = ofs[5] && (ofs[1:0] == 2'b00);
    assign fsel_idx   = ofs[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sh_out <= '0;
            for (int p = 0; p < NUM_PINS; p++) begin
                sh_sel[p] <= (p < 2) ? 5'(SLOT_UART) : 5'(SLOT_GPIO);
            end
        end else if (is_write && !hit_simple && (user_idx == SLOT_W'(SLOT_GPIO))) begin
            if (ofs == GPIO_OUT_OFS) begin
                sh_out <= i_core_req.wdata[NUM_PINS-1:0];
            end else if (fsel_hit) begin
                sh_sel[fsel_idx] <= i_core_req.wdata[4:0];
            end
        end
    end

    // Pending result, taken on the first ready read and dropped by read complete
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend       <= 1'b0;
            rd_ready_q <= 1'b0;
        end else begin
            if (is_read && exp_ready && !pend) begin
                pend       <= 1'b1;
                held_rdata <= exp_rdata;
            end else if (i_read_complete) begin
                pend <= 1'b0;
            end
            rd_ready_q <= is_read && exp_ready;
        end
    end

    always_comb begin
        logic [SLOT_W-1:0] ext;
        exp_rdata = '0;
        exp_ready = 1'b1;
        ext       = user_idx - SLOT_W'(FIRST_EXT_USER);
        if (hit_simple) begin
            if (simple_idx < SLOT_W'(NUM_EXT_SIMPLE)) begin
                exp_rdata[7:0] = i_simple_resp[simple_idx[1:0]].rdata;
            end
        end else if (user_idx == SLOT_W'(SLOT_GPIO)) begin
            if (ofs == GPIO_OUT_OFS) begin
                exp_rdata[NUM_PINS-1:0] = sh_out;
            end else if (ofs == GPIO_IN_OFS) begin
                exp_rdata[NUM_PINS-1:0] = i_ui_in;
            end else if (fsel_hit) begin
                exp_rdata[4:0] = sh_sel[fsel_idx];
            end
        end else if (ext < SLOT_W'(NUM_EXT_USER)) begin
            exp_rdata = i_user_resp[ext[1:0]].rdata;
            exp_ready = i_user_resp[ext[1:0]].ready;
        end
    end

    // Bit p of the slot named by a select, zero for slots with nothing behind them
    function automatic logic pin_source(input int p, input logic [4:0] sel);
        logic [SLOT_W-1:0] n;
        n = sel[3:0];
        if (sel[4]) begin
            return (n < SLOT_W'(NUM_EXT_SIMPLE)) ? i_simple_resp[n[1:0]].uo[p] : 1'b0;
        end
        if (n == SLOT_W'(SLOT_GPIO)) begin
            return sh_out[p];
        end
        n = n - SLOT_W'(FIRST_EXT_USER);
        return (n < SLOT_W'(NUM_EXT_USER)) ? i_user_resp[n[1:0]].uo[p] : 1'b0;
    endfunction

    always_comb begin
        for (int p = 0; p < NUM_PINS; p++) begin
            exp_uo[p] = pin_source(p, sh_sel[p]);
        end
    end

    always_comb begin
        user_req_t   eu;
        simple_req_t es;
        req_ok = 1'b1;
        for (int j = 0; j < NUM_EXT_USER; j++) begin
            eu.offset  = ofs;
            eu.wdata   = i_core_req.wdata;
            eu.write_n = SIZE_NONE;
            eu.read_n  = SIZE_NONE;
            if (!hit_simple && (user_idx == SLOT_W'(FIRST_EXT_USER + j))) begin
                eu.write_n = i_core_req.write_n;
                eu.read_n  = pend ? SIZE_NONE : i_core_req.read_n;
            end
            if (o_user_req[j] != eu) begin
                req_ok = 1'b0;
            end
        end
        for (int k = 0; k < NUM_EXT_SIMPLE; k++) begin
            es.offset = i_core_req.addr[SIMPLE_OFS_W-1:0];
            es.wdata  = i_core_req.wdata[7:0];
            es.write  = hit_simple && is_write && (simple_idx == SLOT_W'(k));
            if (o_simple_req[k] != es) begin
                req_ok = 1'b0;
            end
        end
    end

    a_pins: assert property (@(posedge clk) disable iff (!rst_n) o_uo_out == exp_uo)
        else begin
            $error("ERROR pins expected %h actual %h", $sampled(exp_uo), $sampled(o_uo_out));
            fail_count++;
        end

    // Reads are ready one cycle after a ready slot, writes at once
    a_ready: assert property (@(posedge clk) disable iff (!rst_n)
        o_data_ready == (rd_ready_q || is_write))
        else begin
            $error("ERROR data_ready expected %b actual %b",
                   $sampled(rd_ready_q || is_write), $sampled(o_data_ready));
            fail_count++;
        end

    a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        pend |-> o_data_out == held_rdata)
        else begin
            $error("ERROR data_out expected %h actual %h",
                   $sampled(held_rdata), $sampled(o_data_out));
            fail_count++;
        end

    a_slot_req: assert property (@(posedge clk) disable iff (!rst_n) req_ok)
        else begin
            $error("Slot request wrong for core address %h", $sampled(i_core_req.addr));
            fail_count++;
        end

endmodule

// ==== testbench/tb_periph_top.sv ====
// Testbench for periph_top
// Core-side stimulus, user and simple slot models, per-test report

module tb_periph_top
    import periph_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic                clk = 1'b0;
    logic                rst_n;
    logic [NUM_PINS-1:0] ui_in;
    core_req_t           core_req;
    logic                read_complete;
    user_resp_t          user_resp   [NUM_EXT_USER];
    simple_resp_t        simple_resp [NUM_EXT_SIMPLE];
    logic [NUM_PINS-1:0] uo_out;
    logic [DATA_W-1:0]   data_out;
    logic                data_ready;
    user_req_t           user_req    [NUM_EXT_USER];
    simple_req_t         simple_req  [NUM_EXT_SIMPLE];

    logic [31:0] lfsr_state = 32'hfa86_192a;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          timeouts = 0;
    int          timeout_mark;
    int unsigned fail_mark;
    string       test_name;

    always #5 clk = ~clk;

    periph_top u_periph_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (ui_in),
        .i_core_req      (core_req),
        .i_read_complete (read_complete),
        .i_user_resp     (user_resp),
        .i_simple_resp   (simple_resp),
        .o_uo_out        (uo_out),
        .o_data_out      (data_out),
        .o_data_ready    (data_ready),
        .o_user_req      (user_req),
        .o_simple_req    (simple_req)
    );

    bind periph_top periph_assertions u_assertions (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (i_ui_in),
        .i_core_req      (i_core_req),
        .i_read_complete (i_read_complete),
        .i_user_resp     (i_user_resp),
        .i_simple_resp   (i_simple_resp),
        .o_uo_out        (o_uo_out),
        .o_data_out      (o_data_out),
        .o_data_ready    (o_data_ready),
        .o_user_req      (o_user_req),
        .o_simple_req    (o_simple_req)
    );

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [ADDR_W-1:0] user_addr(input int slot,
                                                    input logic [USER_OFS_W-1:0] ofs);
        return {1'b0, 4'(slot), ofs};
    endfunction

    function automatic logic [ADDR_W-1:0] simple_addr(input int slot,
                                                      input logic [SIMPLE_OFS_W-1:0] ofs);
        return {1'b1, 2'b00, 4'(slot), ofs};
    endfunction

    task automatic start_test(input string name);
        test_name    = name;
        fail_mark    = u_periph_top.u_assertions.fail_count;
        timeout_mark = timeouts;
    endtask

    task automatic end_test();
        int unsigned fails;
        @(negedge clk);
        fails = u_periph_top.u_assertions.fail_count - fail_mark;
        if (fails == 0 && timeouts == timeout_mark) begin
            tests_passed++;
            $display("PASS %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL %s: %0d assertion failures, %0d timeouts",
                     test_name, fails, timeouts - timeout_mark);
        end
    endtask

    // A write finishes in the cycle it is presented
    task automatic write_access(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                                input logic [1:0] size);
        @(negedge clk);
        core_req.addr    = addr;
        core_req.wdata   = data;
        core_req.write_n = size;
        @(negedge clk);
        core_req.write_n = SIZE_NONE;
    endtask

    task automatic read_word(input logic [ADDR_W-1:0] addr, input int hold_cycles);
        int waited;
        @(negedge clk);
        core_req.addr   = addr;
        core_req.read_n = SIZE_WORD;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!data_ready && waited < 20);
        if (!data_ready) begin
            timeouts++;
            $display("%s: no data ready within 20 cycles for address %h", test_name, addr);
        end
        repeat (hold_cycles) @(negedge clk);
        core_req.read_n = SIZE_NONE;
        read_complete   = 1'b1;
        @(negedge clk);
        read_complete   = 1'b0;
    endtask

    // User slot model whose ready rises 0 to 3 cycles into the read
    // The slot moves on to new data once it has been ready for a cycle
    task automatic read_user_slot(input int j, input int hold_cycles);
        int delay;
        user_resp[j].rdata = rand_bits(32);
        user_resp[j].ready = 1'b0;
        delay = int'(rand_bits(2));
        fork
            read_word(user_addr(FIRST_EXT_USER + j, 6'(rand_bits(6))), hold_cycles);
            begin
                @(negedge clk);
                repeat (delay) @(negedge clk);
                user_resp[j].ready = 1'b1;
                @(negedge clk);
                user_resp[j].rdata = rand_bits(32);
            end
        join
    endtask

    task automatic shuffle_slot_pins();
        for (int j = 0; j < NUM_EXT_USER; j++) begin
            user_resp[j].uo = 8'(rand_bits(8));
        end
        for (int k = 0; k < NUM_EXT_SIMPLE; k++) begin
            simple_resp[k].uo    = 8'(rand_bits(8));
            simple_resp[k].rdata = 8'(rand_bits(8));
        end
    endtask

    initial begin
        rst_n            = 1'b0;
        ui_in            = 8'(rand_bits(8));
        core_req         = '0;
        core_req.write_n = SIZE_NONE;
        core_req.read_n  = SIZE_NONE;
        read_complete    = 1'b0;
        for (int j = 0; j < NUM_EXT_USER; j++) begin
            user_resp[j].rdata = '0;
            user_resp[j].ready = 1'b1;
            user_resp[j].uo    = '0;
        end
        for (int k = 0; k < NUM_EXT_SIMPLE; k++) begin
            simple_resp[k].rdata = '0;
            simple_resp[k].uo    = '0;
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        start_test("reset_defaults");
        repeat (4) begin
            shuffle_slot_pins();
            @(negedge clk);
        end
        end_test();

        start_test("gpio_out_in");
        write_access(user_addr(SLOT_GPIO, GPIO_OUT_OFS), rand_bits(32), SIZE_WORD);
        ui_in = 8'(rand_bits(8));
        read_word(user_addr(SLOT_GPIO, GPIO_OUT_OFS), 0);
        read_word(user_addr(SLOT_GPIO, GPIO_IN_OFS), 0);
        end_test();

        start_test("func_sel_simple");
        for (int p = 0; p < NUM_PINS; p++) begin
            write_access(user_addr(SLOT_GPIO, FUNC_SEL_BASE + 6'(4 * p)),
                         32'(16 + p % NUM_EXT_SIMPLE), SIZE_WORD);
        end
        for (int p = 0; p < NUM_PINS; p++) begin
            shuffle_slot_pins();
            read_word(user_addr(SLOT_GPIO, FUNC_SEL_BASE + 6'(4 * p)), 0);
        end
        end_test();

        start_test("user_slot_read");
        for (int j = 0; j < NUM_EXT_USER; j++) begin
            read_user_slot(j, 2);
            read_user_slot(j, 0);
        end
        end_test();

        start_test("slot_strobes");
        for (int j = 0; j < NUM_EXT_USER; j++) begin
            write_access(user_addr(FIRST_EXT_USER + j, 6'(rand_bits(6))), rand_bits(32),
                         SIZE_WORD);
        end
        for (int k = 0; k < NUM_EXT_SIMPLE; k++) begin
            shuffle_slot_pins();
            write_access(simple_addr(k, 4'(rand_bits(4))), rand_bits(32), SIZE_BYTE);
            read_word(simple_addr(k, 4'(rand_bits(4))), 0);
        end
        read_word(user_addr(SLOT_UART, 6'h00), 0);
        read_word(user_addr(9, 6'(rand_bits(6))), 0);
        read_word(simple_addr(7, 4'(rand_bits(4))), 0);
        end_test();

        $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0 && u_periph_top.u_assertions.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
verilog/periph_pkg.sv
verilog/periph_decode.sv
verilog/periph_read_capture.sv
verilog/gpio_regs.sv
verilog/pin_func_mux.sv
verilog/periph_top.sv
testbench/periph_assertions.sv
testbench/tb_periph_top.sv

// ==== Makefile ====
# Verilator build and run for the peripheral interconnect testbench

VERILATOR ?= verilator
TOP       ?= tb_periph_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
